// File: include/cart_rom_params.svh
/*
  widths, region map and bank depths for the cartridge ROM store
  region bases are byte addresses on download index 0
  every region is aligned to its own power-of-two size
  ROM3 has no region of its own, it is loaded into the ROM7 slot
*/
`ifndef CART_ROM_PARAMS_SVH
`define CART_ROM_PARAMS_SVH

// ##########################################################################
// widths
// ##########################################################################
`define CR_DL_ADDR_W    25
`define CR_DL_INDEX_W   8
`define CR_ROM_INDEX    8'd0
`define CR_MAIN_DATA_W  16
`define CR_SND_DATA_W   8
`define CR_MAIN_ADDR_W  15
`define CR_SND_ADDR_W   14
`define CR_MAIN_BANKS   7
`define CR_SND_BANKS    3

// main bank order inside the one-hot vectors
`define CR_BANK_ROM0    0
`define CR_BANK_ROM1    1
`define CR_BANK_ROM2    2
`define CR_BANK_ROM5    3
`define CR_BANK_ROM6    4
`define CR_BANK_ROM7    5
`define CR_BANK_SLAP    6

// ##########################################################################
// region map, byte base and byte size
// ##########################################################################
`define CR_ROM0_BASE    25'h0400000
`define CR_ROM0_SIZE    25'h0008000
`define CR_ROM1_BASE    25'h0410000
`define CR_ROM1_SIZE    25'h0010000
`define CR_ROM2_BASE    25'h0420000
`define CR_ROM2_SIZE    25'h0010000
`define CR_ROM5_BASE    25'h0450000
`define CR_ROM5_SIZE    25'h0010000
`define CR_ROM6_BASE    25'h0460000
`define CR_ROM6_SIZE    25'h0010000
`define CR_ROM7_BASE    25'h0470000
`define CR_ROM7_SIZE    25'h0010000
`define CR_SLAP_BASE    25'h0480000
`define CR_SLAP_SIZE    25'h0008000
`define CR_SROM0_BASE   25'h0488000
`define CR_SROM0_SIZE   25'h0004000
`define CR_SROM1_BASE   25'h048C000
`define CR_SROM1_SIZE   25'h0004000
`define CR_SROM2_BASE   25'h0490000
`define CR_SROM2_SIZE   25'h0004000

`endif

// File: source/cart_rom_pkg.sv
/*
  shared types of the cartridge ROM store
  widths come from the params header
  main addresses are word addresses, sound addresses are byte addresses
*/
`include "cart_rom_params.svh"

package cart_rom_pkg;

	// ######################################################################
	// plain data and address types
	// ######################################################################

	// byte address of the download stream
	typedef logic [`CR_DL_ADDR_W-1:0] dl_addr_t;

	typedef logic [`CR_MAIN_DATA_W-1:0] main_word_t;
	typedef logic [`CR_SND_DATA_W-1:0] snd_byte_t;

	// main side counts words, sound side counts bytes
	typedef logic [`CR_MAIN_ADDR_W-1:0] main_addr_t;
	typedef logic [`CR_SND_ADDR_W-1:0] snd_addr_t;

	// one bit per main bank, see CR_BANK_* for the order
	typedef logic [`CR_MAIN_BANKS-1:0] main_sel_t;

	// ######################################################################
	// load packets, shared by all banks of a group
	// ######################################################################

	// word address within the region, word is high byte first
	typedef struct packed
	{
		main_addr_t addr;
		main_word_t data;
	} main_load_t;

	typedef struct packed
	{
		snd_addr_t addr;
		snd_byte_t data;
	} snd_load_t;

	// ######################################################################
	// CPU read requests
	// ######################################################################

	// main CPU side, selects active low
	typedef struct packed
	{
		logic [4:0] rom_n;
		logic       ma18_n;
		main_addr_t madec;
	} cpu_main_rd_t;

	// sound CPU side
	typedef struct packed
	{
		logic [2:0] srom_n;
		snd_addr_t  sba;
	} cpu_snd_rd_t;

endpackage

// File: source/rom_loader.sv
/*
  turns the download byte stream into bank write strobes
  only index 0 with download high is taken, no back-pressure
  main regions pair bytes high first and write on the odd byte
  regions must be aligned to their size, offsets are plain low bits
  strobes and packets appear one cycle after the accepted byte
*/
`timescale 1ns/10ps
`include "cart_rom_params.svh"

module rom_loader
(
	input  logic                       clk_sys,
	input  logic                       arst_n,
	input  logic                       dl_wr,
	input  logic                       dl_download,
	input  logic [`CR_DL_INDEX_W-1:0]  dl_index,
	input  cart_rom_pkg::dl_addr_t     dl_addr,
	input  cart_rom_pkg::snd_byte_t    dl_data,
	output cart_rom_pkg::main_sel_t    main_we,
	output cart_rom_pkg::main_load_t   main_ld,
	output logic [`CR_SND_BANKS-1:0]   snd_we,
	output cart_rom_pkg::snd_load_t    snd_ld
);

	import cart_rom_pkg::*;

	// region table, same order as the bank strobes
	localparam dl_addr_t MAIN_BASE [`CR_MAIN_BANKS] = '{
		`CR_ROM0_BASE, `CR_ROM1_BASE, `CR_ROM2_BASE, `CR_ROM5_BASE,
		`CR_ROM6_BASE, `CR_ROM7_BASE, `CR_SLAP_BASE};
	localparam dl_addr_t MAIN_SIZE [`CR_MAIN_BANKS] = '{
		`CR_ROM0_SIZE, `CR_ROM1_SIZE, `CR_ROM2_SIZE, `CR_ROM5_SIZE,
		`CR_ROM6_SIZE, `CR_ROM7_SIZE, `CR_SLAP_SIZE};
	localparam dl_addr_t SND_BASE [`CR_SND_BANKS] = '{
		`CR_SROM0_BASE, `CR_SROM1_BASE, `CR_SROM2_BASE};
	localparam dl_addr_t SND_SIZE [`CR_SND_BANKS] = '{
		`CR_SROM0_SIZE, `CR_SROM1_SIZE, `CR_SROM2_SIZE};

	logic                     accept;
	main_sel_t                main_hit;
	logic [`CR_SND_BANKS-1:0] snd_hit;
	snd_byte_t                prev_byte;

	// aligned region, so masking off the offset leaves the base
	function automatic logic in_region(dl_addr_t a, dl_addr_t base, dl_addr_t size);
		return (a & ~(size - 1'b1)) == base;
	endfunction

	// ROM bytes only
	assign accept = dl_wr && dl_download && (dl_index == `CR_ROM_INDEX);

	// region decode
	always_comb
	begin
		for (int i = 0; i < `CR_MAIN_BANKS; i++)
			main_hit[i] = in_region(dl_addr, MAIN_BASE[i], MAIN_SIZE[i]);
		for (int j = 0; j < `CR_SND_BANKS; j++)
			snd_hit[j] = in_region(dl_addr, SND_BASE[j], SND_SIZE[j]);
	end

	// high byte of the next main word
	always_ff @(posedge clk_sys)
	begin
		if (accept)
			prev_byte <= dl_data;
	end

	// ######################################################################
	// strobes
	// ######################################################################
	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			main_we <= '0;
			snd_we  <= '0;
		end
		else
		begin
			// word complete on the odd byte
			main_we <= (accept && dl_addr[0]) ? main_hit : '0;
			snd_we  <= accept ? snd_hit : '0;
		end
	end

	// packets, the strobe decides who takes them
	always_ff @(posedge clk_sys)
	begin
		if (accept)
		begin
			main_ld.addr <= dl_addr[`CR_MAIN_ADDR_W:1];
			main_ld.data <= {prev_byte, dl_data};
			snd_ld.addr  <= dl_addr[`CR_SND_ADDR_W-1:0];
			snd_ld.data  <= dl_data;
		end
	end

	// regions do not overlap, so one bank per byte at most
	a_one_strobe: assert property (@(posedge clk_sys) disable iff (!arst_n)
		$onehot0({main_we, snd_we}))
		else $error("more than one bank strobe");

endmodule

// File: source/rom_bank.sv
/*
  one ROM bank, written from the download side, read by a CPU
  payload type and depth are parameters
  read data is registered, one cycle after the address
  contents are not cleared by reset
*/
`timescale 1ns/10ps
`include "cart_rom_params.svh"

module rom_bank
#(
	parameter type payload_t = cart_rom_pkg::snd_byte_t,
	parameter int  ADDR_W    = `CR_SND_ADDR_W
)
(
	input  logic              clk_sys,
	input  logic              we,
	input  logic [ADDR_W-1:0] wr_addr,
	input  logic [ADDR_W-1:0] rd_addr,
	input  payload_t          wr_data,
	output payload_t          rd_data
);

	// storage, inferred as block RAM
	payload_t mem [0:(1 << ADDR_W) - 1];

	// load port
	always_ff @(posedge clk_sys)
	begin
		if (we)
			mem[wr_addr] <= wr_data;
	end

	// CPU port
	// registered, the read selector lines its selects up with this
	always_ff @(posedge clk_sys)
	begin
		rd_data <= mem[rd_addr];
	end

	// an X strobe would corrupt the whole bank
	a_we_known: assert property (@(posedge clk_sys) !$isunknown(we))
		else $error("bank write strobe unknown");

endmodule

// File: source/rom_read_select.sv
/*
  picks the bank output for the main and the sound CPU
  selects are registered next to the bank read, so the data
  belongs to the request of the previous cycle
  ROM3 is not stored, rom_n[3] reads ROM7 on both MA18n levels
  no active select reads zero
*/
`timescale 1ns/10ps
`include "cart_rom_params.svh"

module rom_read_select
(
	input  logic                      clk_sys,
	input  logic                      arst_n,
	input  cart_rom_pkg::cpu_main_rd_t main_rd,
	input  cart_rom_pkg::cpu_snd_rd_t  snd_rd,
	input  cart_rom_pkg::main_word_t   main_q [`CR_MAIN_BANKS],
	input  cart_rom_pkg::snd_byte_t    snd_q [`CR_SND_BANKS],
	output cart_rom_pkg::main_word_t   mdata,
	output cart_rom_pkg::snd_byte_t    sdata
);

	import cart_rom_pkg::*;

	main_sel_t                main_sel_d;
	main_sel_t                main_sel_q;
	logic [`CR_SND_BANKS-1:0] snd_sel_d;
	logic [`CR_SND_BANKS-1:0] snd_sel_q;

	// ######################################################################
	// main decode, first match wins
	// ######################################################################
	always_comb
	begin
		main_sel_d = '0;
		if (!main_rd.rom_n[0] && main_rd.ma18_n)
			main_sel_d[`CR_BANK_ROM0] = 1'b1;
		else if (!main_rd.rom_n[1] && main_rd.ma18_n)
			main_sel_d[`CR_BANK_ROM1] = 1'b1;
		else if (!main_rd.rom_n[2] && main_rd.ma18_n)
			main_sel_d[`CR_BANK_ROM2] = 1'b1;
		// ROM3 alias
		else if (!main_rd.rom_n[3] && main_rd.ma18_n)
			main_sel_d[`CR_BANK_ROM7] = 1'b1;
		else if (!main_rd.rom_n[1] && !main_rd.ma18_n)
			main_sel_d[`CR_BANK_ROM5] = 1'b1;
		else if (!main_rd.rom_n[2] && !main_rd.ma18_n)
			main_sel_d[`CR_BANK_ROM6] = 1'b1;
		else if (!main_rd.rom_n[3] && !main_rd.ma18_n)
			main_sel_d[`CR_BANK_ROM7] = 1'b1;
		else if (!main_rd.rom_n[4])
			main_sel_d[`CR_BANK_SLAP] = 1'b1;
	end

	// sound decode, lowest select first
	always_comb
	begin
		snd_sel_d = '0;
		if (!snd_rd.srom_n[0])
			snd_sel_d[0] = 1'b1;
		else if (!snd_rd.srom_n[1])
			snd_sel_d[1] = 1'b1;
		else if (!snd_rd.srom_n[2])
			snd_sel_d[2] = 1'b1;
	end

	// aligned with the bank read register
	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			main_sel_q <= '0;
			snd_sel_q  <= '0;
		end
		else
		begin
			main_sel_q <= main_sel_d;
			snd_sel_q  <= snd_sel_d;
		end
	end

	// ######################################################################
	// and-or mux, zero when nothing selected
	// ######################################################################
	always_comb
	begin
		mdata = '0;
		for (int i = 0; i < `CR_MAIN_BANKS; i++)
			if (main_sel_q[i])
				mdata = mdata | main_q[i];
		sdata = '0;
		for (int j = 0; j < `CR_SND_BANKS; j++)
			if (snd_sel_q[j])
				sdata = sdata | snd_q[j];
	end

	// the or-mux relies on this
	a_main_sel: assert property (@(posedge clk_sys) disable iff (!arst_n)
		$onehot0(main_sel_q))
		else $error("main bank choice not one-hot");

endmodule

// File: source/cart_rom_store.sv
/*
  cartridge ROM store, download side and two CPU read sides
  download byte to stored word takes two cycles
  a read returns one cycle after its request, one read per cycle
  ROM0 and SLAP hold 16K words, the other main banks 32K words
*/
`timescale 1ns/10ps
`include "cart_rom_params.svh"

module cart_rom_store
(
	input  logic                       clk_sys,
	input  logic                       arst_n,
	// download stream
	input  logic                       dl_wr,
	input  logic                       dl_download,
	input  logic [`CR_DL_INDEX_W-1:0]  dl_index,
	input  cart_rom_pkg::dl_addr_t     dl_addr,
	input  cart_rom_pkg::snd_byte_t    dl_data,
	// CPU reads
	input  cart_rom_pkg::cpu_main_rd_t main_rd,
	input  cart_rom_pkg::cpu_snd_rd_t  snd_rd,
	output cart_rom_pkg::main_word_t   mdata,
	output cart_rom_pkg::snd_byte_t    sdata
);

	import cart_rom_pkg::*;

	// word address bits per main bank, bytes halved
	localparam int MAIN_AW [`CR_MAIN_BANKS] = '{
		$clog2(`CR_ROM0_SIZE) - 1, $clog2(`CR_ROM1_SIZE) - 1,
		$clog2(`CR_ROM2_SIZE) - 1, $clog2(`CR_ROM5_SIZE) - 1,
		$clog2(`CR_ROM6_SIZE) - 1, $clog2(`CR_ROM7_SIZE) - 1,
		$clog2(`CR_SLAP_SIZE) - 1};

	main_sel_t                main_we;
	main_load_t               main_ld;
	logic [`CR_SND_BANKS-1:0] snd_we;
	snd_load_t                snd_ld;
	main_word_t               main_q [`CR_MAIN_BANKS];
	snd_byte_t                snd_q [`CR_SND_BANKS];

	// ######################################################################
	// load side
	// ######################################################################
	rom_loader i_loader
	(
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.dl_wr       (dl_wr),
		.dl_download (dl_download),
		.dl_index    (dl_index),
		.dl_addr     (dl_addr),
		.dl_data     (dl_data),
		.main_we     (main_we),
		.main_ld     (main_ld),
		.snd_we      (snd_we),
		.snd_ld      (snd_ld)
	);

	// main banks, small ones take the low word address bits only
	for (genvar i = 0; i < `CR_MAIN_BANKS; i++)
	begin : g_main
		rom_bank #(.payload_t(main_word_t), .ADDR_W(MAIN_AW[i])) i_bank
		(
			.clk_sys (clk_sys),
			.we      (main_we[i]),
			.wr_addr (main_ld.addr[MAIN_AW[i]-1:0]),
			.rd_addr (main_rd.madec[MAIN_AW[i]-1:0]),
			.wr_data (main_ld.data),
			.rd_data (main_q[i])
		);
	end

	// sound banks, all the same depth
	for (genvar j = 0; j < `CR_SND_BANKS; j++)
	begin : g_snd
		rom_bank #(.payload_t(snd_byte_t), .ADDR_W(`CR_SND_ADDR_W)) i_bank
		(
			.clk_sys (clk_sys),
			.we      (snd_we[j]),
			.wr_addr (snd_ld.addr),
			.rd_addr (snd_rd.sba),
			.wr_data (snd_ld.data),
			.rd_data (snd_q[j])
		);
	end

	// ######################################################################
	// read side
	// ######################################################################
	rom_read_select i_read_select
	(
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.main_rd (main_rd),
		.snd_rd  (snd_rd),
		.main_q  (main_q),
		.snd_q   (snd_q),
		.mdata   (mdata),
		.sdata   (sdata)
	);

endmodule

// File: tb/tb_clock_gen.sv
/*
  clock and reset for the testbench
  40 ns period, reset low from time zero for 8 rising edges
*/
`timescale 1ns/10ps

module tb_clock_gen
#(
	parameter int HALF_PERIOD  = 20,
	parameter int RESET_CYCLES = 8
)
(
	output logic clk_sys,
	output logic arst_n
);

	initial
	begin
		clk_sys = 1'b0;
		forever
			#(HALF_PERIOD) clk_sys = ~clk_sys;
	end

	// released on a rising edge, like every other input
	initial
	begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		arst_n <= 1'b1;
	end

endmodule

// File: tb/tb_rom_checker.sv
/*
  shadow model of the ROM banks, built from the download ports
  compares mdata and sdata on the falling edge with the request
  taken at the rising edge before
  a selected location that was never loaded counts as an error
*/
`timescale 1ns/10ps
`include "cart_rom_params.svh"

module tb_rom_checker
(
	input  logic                       clk_sys,
	input  logic                       arst_n,
	input  logic                       dl_wr,
	input  logic                       dl_download,
	input  logic [`CR_DL_INDEX_W-1:0]  dl_index,
	input  cart_rom_pkg::dl_addr_t     dl_addr,
	input  cart_rom_pkg::snd_byte_t    dl_data,
	input  cart_rom_pkg::cpu_main_rd_t main_rd,
	input  cart_rom_pkg::cpu_snd_rd_t  snd_rd,
	input  cart_rom_pkg::main_word_t   mdata,
	input  cart_rom_pkg::snd_byte_t    sdata,
	input  logic [127:0]               test_name,
	output int                         chk_count,
	output int                         err_count
);

	import cart_rom_pkg::*;

	// region map straight from the header
	localparam dl_addr_t MAIN_BASE [`CR_MAIN_BANKS] = '{`CR_ROM0_BASE, `CR_ROM1_BASE,
		`CR_ROM2_BASE, `CR_ROM5_BASE, `CR_ROM6_BASE, `CR_ROM7_BASE, `CR_SLAP_BASE};
	localparam dl_addr_t MAIN_SIZE [`CR_MAIN_BANKS] = '{`CR_ROM0_SIZE, `CR_ROM1_SIZE,
		`CR_ROM2_SIZE, `CR_ROM5_SIZE, `CR_ROM6_SIZE, `CR_ROM7_SIZE, `CR_SLAP_SIZE};
	localparam dl_addr_t SND_BASE [`CR_SND_BANKS] = '{`CR_SROM0_BASE, `CR_SROM1_BASE,
		`CR_SROM2_BASE};
	localparam dl_addr_t SND_SIZE [`CR_SND_BANKS] = '{`CR_SROM0_SIZE, `CR_SROM1_SIZE,
		`CR_SROM2_SIZE};
	// bank per rom_n bit, MA18n high and low
	localparam int HI_BANK [4] = '{`CR_BANK_ROM0, `CR_BANK_ROM1, `CR_BANK_ROM2,
		`CR_BANK_ROM7};
	localparam int LO_BANK [4] = '{-1, `CR_BANK_ROM5, `CR_BANK_ROM6, `CR_BANK_ROM7};

	// key is bank in the upper half, offset in the lower
	main_word_t   shadow_main [int];
	snd_byte_t    shadow_snd [int];
	snd_byte_t    last_byte;
	cpu_main_rd_t main_req;
	cpu_snd_rd_t  snd_req;
	logic         armed = 1'b0;
	main_word_t   exp_main;
	snd_byte_t    exp_snd;
	logic         miss_main;
	logic         miss_snd;
	int           n_checks = 0;
	int           n_errors = 0;

	assign chk_count = n_checks;
	assign err_count = n_errors;

	// ##########################################################################
	// shadow of the banks
	// ##########################################################################
	always @(posedge clk_sys)
	begin
		if (dl_wr && dl_download && dl_index == '0)
		begin
			// word goes in on the odd byte, previous byte on top
			for (int b = 0; b < `CR_MAIN_BANKS; b++)
				if (dl_addr[0] && dl_addr >= MAIN_BASE[b] && dl_addr < MAIN_BASE[b] + MAIN_SIZE[b])
					shadow_main[(b << 16) + int'((dl_addr - MAIN_BASE[b]) >> 1)] =
						{last_byte, dl_data};
			for (int s = 0; s < `CR_SND_BANKS; s++)
				if (dl_addr >= SND_BASE[s] && dl_addr < SND_BASE[s] + SND_SIZE[s])
					shadow_snd[(s << 16) + int'(dl_addr - SND_BASE[s])] = dl_data;
			last_byte = dl_data;
		end
	end

	// ##########################################################################
	// reference model of the read side
	// ##########################################################################
	function automatic main_word_t ref_main(cpu_main_rd_t rd, output logic missing);
		int bank;
		int key;
		bank    = -1;
		missing = 1'b0;
		// downward loop, so the lowest active select wins
		if (rd.ma18_n)
		begin
			for (int k = 3; k >= 0; k--)
				if (!rd.rom_n[k])
					bank = HI_BANK[k];
		end
		else
		begin
			for (int k = 3; k >= 1; k--)
				if (!rd.rom_n[k])
					bank = LO_BANK[k];
		end
		if (bank < 0 && !rd.rom_n[4])
			bank = `CR_BANK_SLAP;
		if (bank < 0)
			return '0;
		// word address wraps at the bank's word count
		key = (bank << 16) + (int'(rd.madec) % int'(MAIN_SIZE[bank] >> 1));
		if (!shadow_main.exists(key))
		begin
			missing = 1'b1;
			return '0;
		end
		return shadow_main[key];
	endfunction

	function automatic snd_byte_t ref_snd(cpu_snd_rd_t rd, output logic missing);
		int bank;
		bank    = -1;
		missing = 1'b0;
		for (int k = `CR_SND_BANKS - 1; k >= 0; k--)
			if (!rd.srom_n[k])
				bank = k;
		if (bank < 0)
			return '0;
		if (!shadow_snd.exists((bank << 16) + int'(rd.sba)))
		begin
			missing = 1'b1;
			return '0;
		end
		return shadow_snd[(bank << 16) + int'(rd.sba)];
	endfunction

	// ##########################################################################
	// compare
	// ##########################################################################

	// request as the DUT saw it, nothing selected in reset
	always @(posedge clk_sys)
	begin
		armed <= 1'b1;
		if (!arst_n)
		begin
			main_req <= '1;
			snd_req  <= '1;
		end
		else
		begin
			main_req <= main_rd;
			snd_req  <= snd_rd;
		end
	end

	// outputs settled half a cycle after the edge
	always @(negedge clk_sys)
	begin
		if (armed)
		begin
			exp_main = ref_main(main_req, miss_main);
			exp_snd  = ref_snd(snd_req, miss_snd);
			n_checks = n_checks + 2;
			if (miss_main || miss_snd)
			begin
				n_errors++;
				$display("%0s: read of a ROM location that was never loaded", test_name);
			end
			if (mdata !== exp_main)
			begin
				n_errors++;
				$display("Fail %0s: mdata expected %h actual %h", test_name, exp_main, mdata);
			end
			if (sdata !== exp_snd)
			begin
				n_errors++;
				$display("Fail %0s: sdata expected %h actual %h", test_name, exp_snd, sdata);
			end
		end
	end

endmodule

// File: tb/tb_cart_rom.sv
/*
  testbench top for the cartridge ROM store
  loads over the download port, reads back through both CPU sides
  the checker compares every cycle, this module runs the sequence
  random addresses and data from a fixed seed
*/
`timescale 1ns/10ps
`include "cart_rom_params.svh"

module tb_cart_rom;

	import cart_rom_pkg::*;

	localparam int N_WORDS = 6;
	localparam int N_BYTES = 6;
	localparam int N_RAND  = 40;

	// operations per test, one byte or one read each
	localparam int OPS_RESET  = 12;
	localparam int OPS_MAIN   = `CR_MAIN_BANKS * N_WORDS * 3;
	localparam int OPS_ALIAS  = 4 * N_WORDS + 2;
	localparam int OPS_SND    = `CR_SND_BANKS * N_BYTES * 2;
	localparam int OPS_REJECT = 12;
	localparam int OPS_IDLE   = 6;
	localparam int OPS_RAND   = N_RAND + 2;
	// at most 4 cycles per operation
	localparam int WATCHDOG_CYCLES = 4 * (OPS_RESET + OPS_MAIN + OPS_ALIAS + OPS_SND +
		OPS_REJECT + OPS_IDLE + OPS_RAND) + 100;

	localparam dl_addr_t MAIN_BASE [`CR_MAIN_BANKS] = '{`CR_ROM0_BASE, `CR_ROM1_BASE,
		`CR_ROM2_BASE, `CR_ROM5_BASE, `CR_ROM6_BASE, `CR_ROM7_BASE, `CR_SLAP_BASE};
	localparam dl_addr_t MAIN_SIZE [`CR_MAIN_BANKS] = '{`CR_ROM0_SIZE, `CR_ROM1_SIZE,
		`CR_ROM2_SIZE, `CR_ROM5_SIZE, `CR_ROM6_SIZE, `CR_ROM7_SIZE, `CR_SLAP_SIZE};
	localparam dl_addr_t SND_BASE [`CR_SND_BANKS] = '{`CR_SROM0_BASE, `CR_SROM1_BASE,
		`CR_SROM2_BASE};
	localparam cpu_main_rd_t MAIN_IDLE = {5'b11111, 1'b1, 15'd0};
	localparam cpu_snd_rd_t  SND_IDLE  = {3'b111, 14'd0};

	logic                      clk_sys;
	logic                      arst_n;
	logic                      dl_wr;
	logic                      dl_download;
	logic [`CR_DL_INDEX_W-1:0] dl_index;
	dl_addr_t                  dl_addr;
	snd_byte_t                 dl_data;
	cpu_main_rd_t              main_rd;
	cpu_snd_rd_t               snd_rd;
	main_word_t                mdata;
	snd_byte_t                 sdata;
	logic [127:0]              test_name;
	int                        chk_count;
	int                        err_count;
	int                        chk_start;
	int                        err_start;
	int                        tests_run;
	int                        tests_failed;
	integer                    seed;
	// loaded locations, {bank, word address} and {bank, byte offset}
	logic [17:0]               loaded_main [$];
	logic [15:0]               loaded_snd [$];

	tb_clock_gen i_clock_gen
	(
		.clk_sys (clk_sys),
		.arst_n  (arst_n)
	);

	cart_rom_store i_dut
	(
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.dl_wr       (dl_wr),
		.dl_download (dl_download),
		.dl_index    (dl_index),
		.dl_addr     (dl_addr),
		.dl_data     (dl_data),
		.main_rd     (main_rd),
		.snd_rd      (snd_rd),
		.mdata       (mdata),
		.sdata       (sdata)
	);

	tb_rom_checker i_checker
	(
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.dl_wr       (dl_wr),
		.dl_download (dl_download),
		.dl_index    (dl_index),
		.dl_addr     (dl_addr),
		.dl_data     (dl_data),
		.main_rd     (main_rd),
		.snd_rd      (snd_rd),
		.mdata       (mdata),
		.sdata       (sdata),
		.test_name   (test_name),
		.chk_count   (chk_count),
		.err_count   (err_count)
	);

	// ##########################################################################
	// stimulus helpers
	// ##########################################################################

	// one byte, strobe high for a single cycle
	task automatic send_byte(input logic [7:0] index, input logic download,
		input dl_addr_t addr, input snd_byte_t data);
		@(posedge clk_sys);
		dl_wr       <= 1'b1;
		dl_download <= download;
		dl_index    <= index;
		dl_addr     <= addr;
		dl_data     <= data;
		@(posedge clk_sys);
		dl_wr <= 1'b0;
	endtask

	// high byte on the even address first
	task automatic load_word(input int bank, input main_addr_t waddr, input main_word_t word);
		dl_addr_t addr;
		addr = MAIN_BASE[bank] + dl_addr_t'({waddr, 1'b0});
		send_byte(8'd0, 1'b1, addr, word[15:8]);
		send_byte(8'd0, 1'b1, addr | dl_addr_t'(1), word[7:0]);
	endtask

	// one request per call, back to back when called in a row
	task automatic read_req(input cpu_main_rd_t m, input cpu_snd_rd_t s);
		@(posedge clk_sys);
		main_rd <= m;
		snd_rd  <= s;
	endtask

	// select lines that reach a given main bank
	function automatic cpu_main_rd_t main_req_for(int bank, main_addr_t madec);
		case (bank)
			`CR_BANK_ROM0: return {5'b11110, 1'b1, madec};
			`CR_BANK_ROM1: return {5'b11101, 1'b1, madec};
			`CR_BANK_ROM2: return {5'b11011, 1'b1, madec};
			`CR_BANK_ROM5: return {5'b11101, 1'b0, madec};
			`CR_BANK_ROM6: return {5'b11011, 1'b0, madec};
			`CR_BANK_ROM7: return {5'b10111, 1'b1, madec};
			default:       return {5'b01111, 1'b1, madec};
		endcase
	endfunction

	function automatic cpu_snd_rd_t snd_req_for(logic [1:0] bank, snd_addr_t sba);
		return {~(3'b001 << bank), sba};
	endfunction

	task automatic begin_test(input logic [127:0] name);
		test_name = name;
		chk_start = chk_count;
		err_start = err_count;
	endtask

	// last read compared on the falling edge before the wait ends
	task automatic end_test();
		int errs;
		int checks;
		read_req(MAIN_IDLE, SND_IDLE);
		@(posedge clk_sys);
		errs   = err_count - err_start;
		checks = chk_count - chk_start;
		tests_run++;
		if (errs == 0)
			$display("pass %0s, %0d checks", test_name, checks);
		else
		begin
			tests_failed++;
			$display("%0s finished with %0d errors in %0d checks", test_name, errs, checks);
		end
	endtask

	// ##########################################################################
	// test sequence
	// ##########################################################################
	initial
	begin
		logic [17:0] me;
		logic [15:0] se;
		main_addr_t  waddr;
		main_word_t  word;
		snd_addr_t   off;
		snd_byte_t   data;
		dl_addr_t    addr;
		int          b;
		dl_wr        = 1'b0;
		dl_download  = 1'b0;
		dl_index     = '0;
		dl_addr      = '0;
		dl_data      = '0;
		main_rd      = MAIN_IDLE;
		snd_rd       = SND_IDLE;
		seed         = 95928;
		tests_run    = 0;
		tests_failed = 0;

		// outputs read zero through and right after reset
		begin_test("reset");
		wait (arst_n === 1'b1);
		repeat (3) @(posedge clk_sys);
		end_test();

		// random words into every main region
		begin_test("main_words");
		for (int i = 0; i < `CR_MAIN_BANKS; i++)
			for (int n = 0; n < N_WORDS; n++)
			begin
				waddr = main_addr_t'($random(seed)) & main_addr_t'((MAIN_SIZE[i] >> 1) - 1);
				word  = main_word_t'($random(seed));
				load_word(i, waddr, word);
				loaded_main.push_back({3'(i), waddr});
			end
		for (int i = 0; i < loaded_main.size(); i++)
			read_req(main_req_for(int'(loaded_main[i][17:15]), loaded_main[i][14:0]), SND_IDLE);
		end_test();

		// rom_n[3] on both MA18n levels, ROM5 and ROM6 through MA18n low
		begin_test("rom3_alias");
		for (int i = 0; i < loaded_main.size(); i++)
		begin
			b     = int'(loaded_main[i][17:15]);
			waddr = loaded_main[i][14:0];
			if (b == `CR_BANK_ROM7)
			begin
				read_req({5'b10111, 1'b1, waddr}, SND_IDLE);
				read_req({5'b10111, 1'b0, waddr}, SND_IDLE);
			end
			else if (b == `CR_BANK_ROM5)
				read_req({5'b11101, 1'b0, waddr}, SND_IDLE);
			else if (b == `CR_BANK_ROM6)
				read_req({5'b11011, 1'b0, waddr}, SND_IDLE);
		end
		end_test();

		begin_test("sound_bytes");
		for (int s = 0; s < `CR_SND_BANKS; s++)
			for (int n = 0; n < N_BYTES; n++)
			begin
				off  = snd_addr_t'($random(seed));
				data = snd_byte_t'($random(seed));
				send_byte(8'd0, 1'b1, SND_BASE[s] + dl_addr_t'(off), data);
				loaded_snd.push_back({2'(s), off});
			end
		for (int i = 0; i < loaded_snd.size(); i++)
			read_req(MAIN_IDLE, snd_req_for(loaded_snd[i][15:14], loaded_snd[i][13:0]));
		end_test();

		// wrong index or download low, stored values must hold
		begin_test("rejected_bytes");
		me   = loaded_main[0];
		se   = loaded_snd[0];
		addr = MAIN_BASE[me[17:15]] + dl_addr_t'({me[14:0], 1'b0});
		send_byte(8'd1, 1'b1, addr, 8'hA5);
		send_byte(8'd1, 1'b1, addr | dl_addr_t'(1), 8'h5A);
		send_byte(8'd0, 1'b0, addr, 8'h3C);
		send_byte(8'd0, 1'b0, addr | dl_addr_t'(1), 8'hC3);
		addr = SND_BASE[se[15:14]] + dl_addr_t'(se[13:0]);
		send_byte(8'd2, 1'b1, addr, 8'h96);
		send_byte(8'd0, 1'b0, addr, 8'h69);
		read_req(main_req_for(int'(me[17:15]), me[14:0]), snd_req_for(se[15:14], se[13:0]));
		end_test();

		// rom_n[0] only counts with MA18n high
		begin_test("no_select");
		read_req(MAIN_IDLE, SND_IDLE);
		read_req({5'b11111, 1'b0, 15'h1234}, {3'b111, 14'h0123});
		read_req({5'b11110, 1'b0, 15'h0042}, SND_IDLE);
		end_test();

		// a new request on every cycle, both CPUs at once
		begin_test("random_reads");
		for (int n = 0; n < N_RAND; n++)
		begin
			me = loaded_main[$unsigned($random(seed)) % loaded_main.size()];
			se = loaded_snd[$unsigned($random(seed)) % loaded_snd.size()];
			read_req(main_req_for(int'(me[17:15]), me[14:0]), snd_req_for(se[15:14], se[13:0]));
		end
		end_test();

		$display("%0d tests run, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, chk_count, err_count);
		if (tests_failed == 0 && err_count == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	// ##########################################################################
	// watchdog
	// ##########################################################################
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("watchdog expired after %0d cycles, the test sequence did not finish",
			WATCHDOG_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// File: compile.f
+incdir+include
source/cart_rom_pkg.sv
source/rom_loader.sv
source/rom_bank.sv
source/rom_read_select.sv
source/cart_rom_store.sv
tb/tb_clock_gen.sv
tb/tb_rom_checker.sv
tb/tb_cart_rom.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs the cartridge ROM store testbench with Verilator
# a build error, a crash or a fail line in the log makes the run fail

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_cart_rom \
	-f compile.f -o tb_cart_rom > sim.log 2>&1 \
	&& ./obj_dir/tb_cart_rom >> sim.log 2>&1 \
	|| echo "TEST FAILED" >> sim.log

cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST OK" sim.log || exit 1
exit 0
